// File: Makefile
# Verilator build for the multi-h demodulator top level
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_multihTop
DUT_TOP   ?= multihTop
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: busControl.sv
/* Host bus control with miscellaneous space decode, soft reset request,
   DAC reset stretcher and read data mux */
module busControl (
  input  logic              ck933,
  input  logic              rs,
  input  logic              nCs_i,
  input  logic              nWe_i,
  input  logic              nRd_i,
  input  demodPkg::addrT    addr_i,
  input  demodPkg::busWordT wrData_i,
  output demodPkg::busWordT rdData_o,
  output logic              dacRst_o
);
  import demodPkg::*;

  logic                            miscSpace;
  logic                            versionSel;
  logic                            resetSel;
  logic                            softReq;
  busWordT                         miscData;
  logic [1:0]                      reqSync;
  logic [$bits(RESET_STRETCH)-1:0] stretchCount;
  logic                            dacRst;

  //********************************************************************
  // Address decode
  //********************************************************************
  assign miscSpace = (addr_i[ADDR_W-1:MISC_SPACE_LSB]
                      == MISC_SPACE_BASE[ADDR_W-1:MISC_SPACE_LSB]);

  // Word pairs inside the space where bit 1 selects the half
  assign versionSel = miscSpace
                      && (addr_i[MISC_SPACE_LSB-1:2] == MISC_VERSION[MISC_SPACE_LSB-1:2]);
  assign resetSel   = miscSpace
                      && (addr_i[MISC_SPACE_LSB-1:2] == MISC_RESET[MISC_SPACE_LSB-1:2]);

  // Writing a 1 to bit 0 requests the reset
  assign softReq = !nCs_i && !nWe_i && resetSel && wrData_i[0];

  //********************************************************************
  // Reset stretcher
  //********************************************************************
  // Request edge goes through two flops, then the counter holds the
  // DAC reset for RESET_STRETCH + 1 cycles
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      reqSync      <= 2'b11;
      stretchCount <= RESET_STRETCH;
      dacRst       <= 1'b1;
    end else begin
      reqSync <= {reqSync[0], softReq};
      if (reqSync[0] && !reqSync[1]) begin  // New request
        stretchCount <= RESET_STRETCH;
        dacRst       <= 1'b1;
      end else if (stretchCount != '0) begin
        stretchCount <= stretchCount - 1'b1;
        dacRst       <= 1'b1;
      end else begin
        dacRst <= 1'b0;
      end
    end
  end

  assign dacRst_o = dacRst;

  //********************************************************************
  // Read data mux
  //********************************************************************
  // Version word halves with a zero lower half
  always_comb begin
    if (addr_i[1]) begin
      miscData = VER_NUMBER;
    end else begin
      miscData = '0;
    end
  end

  // Unmapped and idle reads return zero
  always_comb begin
    rdData_o = '0;
    if (!nCs_i && !nRd_i && versionSel) begin
      rdData_o = miscData;
    end
  end

endmodule

// File: dacChannel.sv
/* One DAC output channel that picks host or trellis samples and drives
   the offset-binary DAC pins on the channel sync */
module dacChannel (
  input  logic              ck933,
  input  logic              rs,
  input  logic              multihMode_i,
  input  demodPkg::dacSelT  dacSelect_i,
  input  demodPkg::dacT     hostData_i,
  input  demodPkg::trellisT trellisData_i,
  input  logic              trellisSync_i,
  output demodPkg::dacT     dacD_o,
  output logic              dacClk_o
);
  import demodPkg::*;

  logic useTrellis;
  dacT  selData;
  logic selSync;

  always_comb begin
    case (dacSelect_i)
      DAC_TRELLIS_I,
      DAC_TRELLIS_Q,
      DAC_TRELLIS_PHERR,
      DAC_TRELLIS_INDEX: useTrellis = multihMode_i;
      default:           useTrellis = 1'b0;
    endcase
  end

  // Source select register
  always_ff @(posedge ck933) begin
    selData <= useTrellis ? trellisData_i[TRELLIS_W-1 -: DAC_W] : hostData_i;
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      selSync <= 1'b0;
    end else begin
      selSync <= useTrellis ? trellisSync_i : 1'b1;  // Host data every cycle
    end
  end

  // Pin register flips the MSB for offset binary
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dacD_o <= '0;
    end else if (selSync) begin
      dacD_o <= {~selData[DAC_W-1], selData[DAC_W-2:0]};
    end
  end

  assign dacClk_o = ck933;

endmodule

// File: dataOutputSelect.sv
/* Picks the trellis or legacy decisions for the clock and data pins
   and applies the AUQPSK override on the Q pins */
module dataOutputSelect (
  input  logic           ck933,
  input  logic           rs,
  input  demodPkg::modeT demodMode_i,
  symbolIf.dst           legacySym,
  symbolIf.dst           multihSym,
  input  logic           auSymClkR_i,
  input  logic           qDataR_i,
  output logic           cout_i_o,
  output logic           dout_i_o,
  output logic           cout_q_o,
  output logic           dout_q_o
);
  import demodPkg::*;

  logic trellisEn;
  logic auqpskMode;
  logic decSymEn;
  logic decSym2xEn;
  logic decI;
  logic decQ;

  assign trellisEn  = (demodMode_i == MODE_MULTIH);
  assign auqpskMode = (demodMode_i == MODE_AUQPSK);

  //********************************************************************
  // Decoder source select
  //********************************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      decSymEn   <= 1'b0;
      decSym2xEn <= 1'b0;
      decI       <= 1'b0;
      decQ       <= 1'b0;
    end else if (trellisEn) begin
      decSymEn   <= multihSym.symEn;
      decSym2xEn <= multihSym.sym2xEn;
      decI       <= multihSym.iBit;
      decQ       <= multihSym.qBit;
    end else begin
      decSymEn   <= legacySym.symEn;
      decSym2xEn <= legacySym.sym2xEn;
      decI       <= legacySym.iBit;
      decQ       <= legacySym.qBit;
    end
  end

  //********************************************************************
  // Clock and data pins
  //********************************************************************
  assign cout_i_o = decSymEn;
  assign dout_i_o = decI;

  // Q clock carries the half-symbol strobe outside AUQPSK
  assign cout_q_o = auqpskMode ? auSymClkR_i : decSym2xEn;
  assign dout_q_o = auqpskMode ? qDataR_i : decQ;

endmodule

// File: demodPkg.sv
/* Shared definitions for the multi-h demodulator top level
   covering the host address map, mode and DAC select codes and sample types */
package demodPkg;

  //********************************************************************
  // Host bus
  //********************************************************************
  localparam int ADDR_W = 12;  // Word address with bit 0 unused
  localparam int BUS_W  = 16;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [BUS_W-1:0]  busWordT;

  // Firmware version in the upper half of the version word
  localparam busWordT VER_NUMBER = 16'h0079;

  // Miscellaneous space covers 16 byte addresses
  localparam int   MISC_SPACE_LSB  = 4;
  localparam addrT MISC_SPACE_BASE = 12'h0F0;
  localparam addrT MISC_VERSION    = 12'h0F0;  // Bit 1 picks the half
  localparam addrT MISC_RESET      = 12'h0F4;

  //********************************************************************
  // Demodulator mode and DAC source codes
  //********************************************************************
  typedef logic [3:0] modeT;

  localparam modeT MODE_AUQPSK = 4'h6;
  localparam modeT MODE_MULTIH = 4'hA;

  typedef logic [3:0] dacSelT;

  // Codes that route trellis channel data to a DAC
  localparam dacSelT DAC_TRELLIS_I     = 4'h8;
  localparam dacSelT DAC_TRELLIS_Q     = 4'h9;
  localparam dacSelT DAC_TRELLIS_PHERR = 4'hA;
  localparam dacSelT DAC_TRELLIS_INDEX = 4'hB;

  //********************************************************************
  // Sample widths
  //********************************************************************
  localparam int TRELLIS_W = 18;
  localparam int DAC_W     = 14;  // Upper bits of a trellis sample
  localparam int NUM_DAC   = 3;

  typedef logic [TRELLIS_W-1:0] trellisT;
  typedef logic [DAC_W-1:0]     dacT;

  // Reload value of the DAC reset stretch counter
  localparam logic [2:0] RESET_STRETCH = 3'd5;

endpackage

// File: files.f
demodPkg.sv
symbolIf.sv
busControl.sv
inputReclock.sv
dacChannel.sv
dataOutputSelect.sv
multihTop.sv
tb_multihTop.sv

// File: inputReclock.sv
/* Registers every asynchronous demodulator input once and gates the
   multi-h symbol enables by the demodulator mode */
module inputReclock (
  input  logic                                ck933,
  input  logic                                rs,
  input  demodPkg::modeT                      demodMode_i,
  input  demodPkg::dacT     [demodPkg::NUM_DAC-1:0] dacData_i,
  input  demodPkg::trellisT [demodPkg::NUM_DAC-1:0] trellisData_i,
  input  logic              [demodPkg::NUM_DAC-1:0] trellisSync_i,
  input  logic                                multihSymEn_i,
  input  logic                                multihSym2xEn_i,
  input  logic              [1:0]             multihBit_i,
  input  logic                                dataSymEn_i,
  input  logic                                dataSym2xEn_i,
  input  logic                                iData_i,
  input  logic                                qData_i,
  input  logic                                auSymClk_i,
  output demodPkg::modeT                      demodModeR_o,
  output demodPkg::dacT     [demodPkg::NUM_DAC-1:0] dacDataR_o,
  output demodPkg::trellisT [demodPkg::NUM_DAC-1:0] trellisDataR_o,
  output logic              [demodPkg::NUM_DAC-1:0] trellisSyncR_o,
  output logic                                auSymClkR_o,
  output logic                                qDataR_o,
  symbolIf.src                                legacySym,
  symbolIf.src                                multihSym
);
  import demodPkg::*;

  logic multihMode;

  // Raw mode blocks the enables from the first cycle on
  assign multihMode = (demodMode_i == MODE_MULTIH);

  // Sample payload
  always_ff @(posedge ck933) begin
    dacDataR_o     <= dacData_i;
    trellisDataR_o <= trellisData_i;
    multihSym.iBit <= multihBit_i[0];
    multihSym.qBit <= multihBit_i[1];
    legacySym.iBit <= iData_i;
    qDataR_o       <= qData_i;
  end

  assign legacySym.qBit = qDataR_o;  // Same flop feeds the AUQPSK path

  // Strobes, syncs and mode
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      demodModeR_o      <= '0;
      trellisSyncR_o    <= '0;
      multihSym.symEn   <= 1'b0;
      multihSym.sym2xEn <= 1'b0;
      legacySym.symEn   <= 1'b0;
      legacySym.sym2xEn <= 1'b0;
      auSymClkR_o       <= 1'b0;
    end else begin
      demodModeR_o      <= demodMode_i;
      trellisSyncR_o    <= trellisSync_i;
      multihSym.symEn   <= multihSymEn_i & multihMode;
      multihSym.sym2xEn <= multihSym2xEn_i & multihMode;
      legacySym.symEn   <= dataSymEn_i;
      legacySym.sym2xEn <= dataSym2xEn_i;
      auSymClkR_o       <= auSymClk_i;
    end
  end

endmodule

// File: multihTop.sv
/* Multi-h demodulator top level with host bus, DAC reset, input
   reclocking, three DAC channels and the clock and data output pins */
module multihTop (
  input  logic              ck933,
  input  logic              rs,
  // Host bus
  input  logic              nCs_i,
  input  logic              nWe_i,
  input  logic              nRd_i,
  input  demodPkg::addrT    addr_i,
  input  demodPkg::busWordT wrData_i,
  output demodPkg::busWordT rdData_o,
  output logic              dacRst_o,
  // Demodulator inputs
  input  demodPkg::modeT    demodMode_i,
  input  demodPkg::dacSelT  dac0Select_i,
  input  demodPkg::dacSelT  dac1Select_i,
  input  demodPkg::dacSelT  dac2Select_i,
  input  demodPkg::dacT     dac0Data_i,
  input  demodPkg::dacT     dac1Data_i,
  input  demodPkg::dacT     dac2Data_i,
  input  demodPkg::trellisT trellis0Data_i,
  input  demodPkg::trellisT trellis1Data_i,
  input  demodPkg::trellisT trellis2Data_i,
  input  logic              trellis0Sync_i,
  input  logic              trellis1Sync_i,
  input  logic              trellis2Sync_i,
  input  logic              multihSymEn_i,
  input  logic              multihSym2xEn_i,
  input  logic [1:0]        multihBit_i,
  input  logic              dataSymEn_i,
  input  logic              dataSym2xEn_i,
  input  logic              iData_i,
  input  logic              qData_i,
  input  logic              auSymClk_i,
  input  logic              bsyncLockInput_i,
  input  logic              demodLockInput_i,
  input  logic              sdiInput_i,
  // DAC pins
  output demodPkg::dacT     dac0D_o,
  output demodPkg::dacT     dac1D_o,
  output demodPkg::dacT     dac2D_o,
  output logic              dac0Clk_o,
  output logic              dac1Clk_o,
  output logic              dac2Clk_o,
  // Clock and data pins
  output logic              cout_i_o,
  output logic              dout_i_o,
  output logic              cout_q_o,
  output logic              dout_q_o,
  output logic              bsyncNLock_o,
  output logic              demodNLock_o,
  output logic              sdiOut_o
);
  import demodPkg::*;

  modeT                  demodModeR;
  dacT     [NUM_DAC-1:0] dacDataR;
  trellisT [NUM_DAC-1:0] trellisDataR;
  logic    [NUM_DAC-1:0] trellisSyncR;
  dacSelT  [NUM_DAC-1:0] dacSelect;
  dacT     [NUM_DAC-1:0] dacD;
  logic    [NUM_DAC-1:0] dacClk;
  logic                  auSymClkR;
  logic                  qDataR;
  logic                  multihMode;

  symbolIf legacySym ();
  symbolIf multihSym ();

  //********************************************************************
  // Pass-throughs
  //********************************************************************
  assign bsyncNLock_o = bsyncLockInput_i;
  assign demodNLock_o = demodLockInput_i;
  assign sdiOut_o     = sdiInput_i;

  //********************************************************************
  // Host bus and DAC reset
  //********************************************************************
  busControl uBusControl (
    .ck933    (ck933),
    .rs       (rs),
    .nCs_i    (nCs_i),
    .nWe_i    (nWe_i),
    .nRd_i    (nRd_i),
    .addr_i   (addr_i),
    .wrData_i (wrData_i),
    .rdData_o (rdData_o),
    .dacRst_o (dacRst_o)
  );

  //********************************************************************
  // Input reclocking
  //********************************************************************
  inputReclock uInputReclock (
    .ck933           (ck933),
    .rs              (rs),
    .demodMode_i     (demodMode_i),
    .dacData_i       ({dac2Data_i, dac1Data_i, dac0Data_i}),
    .trellisData_i   ({trellis2Data_i, trellis1Data_i, trellis0Data_i}),
    .trellisSync_i   ({trellis2Sync_i, trellis1Sync_i, trellis0Sync_i}),
    .multihSymEn_i   (multihSymEn_i),
    .multihSym2xEn_i (multihSym2xEn_i),
    .multihBit_i     (multihBit_i),
    .dataSymEn_i     (dataSymEn_i),
    .dataSym2xEn_i   (dataSym2xEn_i),
    .iData_i         (iData_i),
    .qData_i         (qData_i),
    .auSymClk_i      (auSymClk_i),
    .demodModeR_o    (demodModeR),
    .dacDataR_o      (dacDataR),
    .trellisDataR_o  (trellisDataR),
    .trellisSyncR_o  (trellisSyncR),
    .auSymClkR_o     (auSymClkR),
    .qDataR_o        (qDataR),
    .legacySym       (legacySym),
    .multihSym       (multihSym)
  );

  //********************************************************************
  // DAC outputs
  //********************************************************************
  assign multihMode = (demodModeR == MODE_MULTIH);  // Shared by all channels
  assign dacSelect  = {dac2Select_i, dac1Select_i, dac0Select_i};

  for (genvar ch = 0; ch < NUM_DAC; ch++) begin : gDac
    dacChannel uDacChannel (
      .ck933         (ck933),
      .rs            (rs),
      .multihMode_i  (multihMode),
      .dacSelect_i   (dacSelect[ch]),
      .hostData_i    (dacDataR[ch]),
      .trellisData_i (trellisDataR[ch]),
      .trellisSync_i (trellisSyncR[ch]),
      .dacD_o        (dacD[ch]),
      .dacClk_o      (dacClk[ch])
    );
  end

  assign dac0D_o   = dacD[0];
  assign dac1D_o   = dacD[1];
  assign dac2D_o   = dacD[2];
  assign dac0Clk_o = dacClk[0];
  assign dac1Clk_o = dacClk[1];
  assign dac2Clk_o = dacClk[2];

  //********************************************************************
  // Decoder source and output pins
  //********************************************************************
  dataOutputSelect uDataOutputSelect (
    .ck933       (ck933),
    .rs          (rs),
    .demodMode_i (demodModeR),
    .legacySym   (legacySym),
    .multihSym   (multihSym),
    .auSymClkR_i (auSymClkR),
    .qDataR_i    (qDataR),
    .cout_i_o    (cout_i_o),
    .dout_i_o    (dout_i_o),
    .cout_q_o    (cout_q_o),
    .dout_q_o    (dout_q_o)
  );

endmodule

// File: symbolIf.sv
/* One demodulator symbol stream with its enables and I/Q decision bits */
interface symbolIf;

  logic symEn;    // Single cycle strobe per symbol
  logic sym2xEn;  // Strobe at twice the symbol rate
  logic iBit;     // Valid while symEn is high
  logic qBit;

  modport src (
    output symEn,
    output sym2xEn,
    output iBit,
    output qBit
  );

  modport dst (
    input symEn,
    input sym2xEn,
    input iBit,
    input qBit
  );

endinterface

// File: tb_multihTop.sv
/* Directed testbench for the multi-h demodulator top level covering the host bus,
   DAC reset, DAC channels and the clock and data pins */
module tb_multihTop;
  import demodPkg::*;

  localparam int          HALF_PERIOD = 20;
  localparam logic [31:0] SEED        = 32'h982c_3cc2;

  logic                  ck933;
  logic                  rs;
  logic                  nCs;
  logic                  nWe;
  logic                  nRd;
  addrT                  addr;
  busWordT               wrData;
  busWordT               rdData;
  logic                  dacRst;
  modeT                  demodMode;
  dacSelT  [NUM_DAC-1:0] dacSelect;
  dacT     [NUM_DAC-1:0] hostData;
  trellisT [NUM_DAC-1:0] trellisData;
  logic    [NUM_DAC-1:0] trellisSync;
  logic                  multihSymEn;
  logic                  multihSym2xEn;
  logic    [1:0]         multihBit;
  logic                  dataSymEn;
  logic                  dataSym2xEn;
  logic                  iData;
  logic                  qData;
  logic                  auSymClk;
  logic                  bsyncLock;
  logic                  demodLock;
  logic                  sdiIn;
  dacT     [NUM_DAC-1:0] dacD;
  logic    [NUM_DAC-1:0] dacClk;
  logic                  coutI;
  logic                  doutI;
  logic                  coutQ;
  logic                  doutQ;
  logic                  bsyncNLock;
  logic                  demodNLock;
  logic                  sdiOut;

  dacT     [NUM_DAC-1:0] dacExp;  // Expected DAC pins
  int                    errorCount;
  int                    testCount;

  multihTop u_dut (
    .ck933 (ck933), .rs (rs),
    .nCs_i (nCs), .nWe_i (nWe), .nRd_i (nRd),
    .addr_i (addr), .wrData_i (wrData), .rdData_o (rdData), .dacRst_o (dacRst),
    .demodMode_i (demodMode),
    .dac0Select_i (dacSelect[0]), .dac1Select_i (dacSelect[1]), .dac2Select_i (dacSelect[2]),
    .dac0Data_i (hostData[0]), .dac1Data_i (hostData[1]), .dac2Data_i (hostData[2]),
    .trellis0Data_i (trellisData[0]), .trellis1Data_i (trellisData[1]),
    .trellis2Data_i (trellisData[2]),
    .trellis0Sync_i (trellisSync[0]), .trellis1Sync_i (trellisSync[1]),
    .trellis2Sync_i (trellisSync[2]),
    .multihSymEn_i (multihSymEn), .multihSym2xEn_i (multihSym2xEn), .multihBit_i (multihBit),
    .dataSymEn_i (dataSymEn), .dataSym2xEn_i (dataSym2xEn),
    .iData_i (iData), .qData_i (qData), .auSymClk_i (auSymClk),
    .bsyncLockInput_i (bsyncLock), .demodLockInput_i (demodLock), .sdiInput_i (sdiIn),
    .dac0D_o (dacD[0]), .dac1D_o (dacD[1]), .dac2D_o (dacD[2]),
    .dac0Clk_o (dacClk[0]), .dac1Clk_o (dacClk[1]), .dac2Clk_o (dacClk[2]),
    .cout_i_o (coutI), .dout_i_o (doutI), .cout_q_o (coutQ), .dout_q_o (doutQ),
    .bsyncNLock_o (bsyncNLock), .demodNLock_o (demodNLock), .sdiOut_o (sdiOut)
  );

  initial begin
    ck933 = 1'b0;
    forever #HALF_PERIOD ck933 = ~ck933;
  end

  //**********************************************************************
  // Compare and timing helpers
  //**********************************************************************
  task automatic checkBus(input string name, input busWordT got, input busWordT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkDac(input string name, input dacT got, input dacT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errorCount++;
    end
  endtask

  // Offset binary flips the MSB
  function automatic dacT offsetBin(input dacT sample);
    return sample ^ {1'b1, {(DAC_W-1){1'b0}}};
  endfunction

  task automatic skipCycles(input int n);
    repeat (n) @(negedge ck933);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    $display("%s: %0d errors", name, errorCount - errorsBefore);
  endtask

  // Counts falling edges with dacRst_o high up to the first low one
  task automatic measureResetHigh(output int cycles);
    cycles = 0;
    while (dacRst && cycles < 20) begin
      cycles++;
      @(negedge ck933);
    end
    if (dacRst) begin
      $display("dacRst_o stayed high for more than 20 cycles");
      errorCount++;
    end
  endtask

  task automatic waitDacSettle(input int limit);
    int cycles;
    cycles = 0;
    while (dacD !== dacExp && cycles < limit) begin
      @(negedge ck933);
      cycles++;
    end
    if (dacD !== dacExp) begin
      $display("DAC pins did not settle on the expected samples within %0d cycles", limit);
      errorCount++;
    end
  endtask

  task automatic busRead(input addrT a, input logic rdN);
    nCs  = 1'b0;
    nRd  = rdN;
    addr = a;
    skipCycles(1);
  endtask

  //**********************************************************************
  // Tests
  //**********************************************************************
  // Entered on the falling edge that releases rs
  task automatic stretchDacReset();
    int errorsBefore;
    int highCycles;
    int waitCount;
    errorsBefore = errorCount;
    measureResetHigh(highCycles);
    checkCount("dacRst_o high cycles after rs", highCycles, 6);
    skipCycles(3);
    nCs    = 1'b0;  // Soft reset write
    nWe    = 1'b0;
    addr   = MISC_RESET;
    wrData = 16'h0001;
    @(negedge ck933);
    nCs       = 1'b1;
    nWe       = 1'b1;
    wrData    = '0;
    waitCount = 1;
    while (!dacRst && waitCount < 8) begin
      @(negedge ck933);
      waitCount++;
    end
    if (!dacRst) begin
      $display("dacRst_o did not rise after the soft reset write");
      errorCount++;
    end else begin
      checkCount("dacRst_o rise latency", waitCount, 2);
      measureResetHigh(highCycles);
      checkCount("dacRst_o high cycles after soft reset", highCycles, 6);
    end
    repeat (8) begin
      checkBit("dacRst_o after stretch", dacRst, 1'b0);
      @(negedge ck933);
    end
    reportTest("reset stretch", errorsBefore);
  endtask

  task automatic readVersionWord();
    int errorsBefore;
    errorsBefore = errorCount;
    busRead(MISC_VERSION | 12'h002, 1'b0);
    checkBus("rdData_o version upper", rdData, VER_NUMBER);
    busRead(MISC_VERSION, 1'b0);
    checkBus("rdData_o version lower", rdData, 16'h0000);
    busRead(12'h123, 1'b0);
    checkBus("rdData_o unmapped", rdData, 16'h0000);
    busRead(MISC_VERSION | 12'h002, 1'b1);
    checkBus("rdData_o with nRd high", rdData, 16'h0000);
    nCs  = 1'b1;
    nRd  = 1'b1;
    addr = '0;
    reportTest("version read", errorsBefore);
  endtask

  task automatic driveHostSamples();
    int          errorsBefore;
    logic [31:0] rnd;
    errorsBefore = errorCount;
    dacSelect    = {4'h2, 4'h1, 4'h0};  // No trellis codes
    for (int i = 0; i < 6; i++) begin
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        rnd          = $urandom();
        hostData[ch] = rnd[DAC_W-1:0];
      end
      skipCycles(2);
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        checkDac($sformatf("dac%0dD_o before latency", ch), dacD[ch], dacExp[ch]);
      end
      skipCycles(1);
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        dacExp[ch] = offsetBin(hostData[ch]);
        checkDac($sformatf("dac%0dD_o host", ch), dacD[ch], dacExp[ch]);
      end
    end
    // DAC clock pins follow the system clock in both phases
    @(posedge ck933);
    #(HALF_PERIOD / 2);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      checkBit($sformatf("dac%0dClk_o high phase", ch), dacClk[ch], 1'b1);
    end
    @(negedge ck933);
    #(HALF_PERIOD / 2);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      checkBit($sformatf("dac%0dClk_o low phase", ch), dacClk[ch], 1'b0);
    end
    @(negedge ck933);
    reportTest("host DAC path", errorsBefore);
  endtask

  task automatic driveTrellisSamples();
    int                 errorsBefore;
    logic [31:0]        rnd;
    logic [NUM_DAC-1:0] syncSample;
    errorsBefore = errorCount;
    demodMode    = MODE_MULTIH;
    dacSelect    = {DAC_TRELLIS_PHERR, DAC_TRELLIS_Q, DAC_TRELLIS_I};
    skipCycles(4);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      checkDac($sformatf("dac%0dD_o held on mode change", ch), dacD[ch], dacExp[ch]);
    end
    for (int i = 0; i < 8; i++) begin
      if (i == 4) begin
        dacSelect[2] = DAC_TRELLIS_INDEX;
      end
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        rnd             = $urandom();
        trellisData[ch] = rnd[TRELLIS_W-1:0];
        syncSample[ch]  = (i == 0) ? 1'b1 : (i == 1) ? 1'b0 : rnd[31];
      end
      trellisSync = syncSample;
      skipCycles(1);
      trellisSync = '0;  // Sync is a one cycle strobe
      skipCycles(2);
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        if (syncSample[ch]) begin
          dacExp[ch] = offsetBin(dacT'(trellisData[ch] >> (TRELLIS_W - DAC_W)));
        end
        checkDac($sformatf("dac%0dD_o trellis", ch), dacD[ch], dacExp[ch]);
      end
    end
    // Back to host data outside multi-h
    demodMode = 4'h0;
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      dacExp[ch] = offsetBin(hostData[ch]);
    end
    waitDacSettle(10);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      checkDac($sformatf("dac%0dD_o host again", ch), dacD[ch], dacExp[ch]);
    end
    reportTest("trellis DAC path", errorsBefore);
  endtask

  task automatic selectDecoderSource();
    int          errorsBefore;
    logic [31:0] rnd;
    errorsBefore = errorCount;
    demodMode    = MODE_MULTIH;
    skipCycles(3);
    for (int i = 0; i < 8; i++) begin
      rnd           = $urandom();
      multihSymEn   = rnd[0];
      multihSym2xEn = rnd[3];
      multihBit     = rnd[2:1];
      dataSymEn     = ~rnd[0];  // Legacy stream always differs
      dataSym2xEn   = ~rnd[3];
      iData         = ~rnd[1];
      qData         = ~rnd[2];
      skipCycles(2);
      checkBit("cout_i_o multi-h", coutI, multihSymEn);
      checkBit("dout_i_o multi-h", doutI, multihBit[0]);
      checkBit("cout_q_o multi-h", coutQ, multihSym2xEn);
      checkBit("dout_q_o multi-h", doutQ, multihBit[1]);
    end
    demodMode = 4'h0;
    skipCycles(3);
    for (int i = 0; i < 8; i++) begin
      rnd           = $urandom();
      dataSymEn     = rnd[0];
      dataSym2xEn   = rnd[3];
      iData         = rnd[1];
      qData         = rnd[2];
      multihSymEn   = ~rnd[0];
      multihSym2xEn = ~rnd[3];
      multihBit     = ~rnd[2:1];
      skipCycles(2);
      checkBit("cout_i_o legacy", coutI, dataSymEn);
      checkBit("dout_i_o legacy", doutI, iData);
      checkBit("cout_q_o legacy", coutQ, dataSym2xEn);
      checkBit("dout_q_o legacy", doutQ, qData);
    end
    multihSymEn   = 1'b0;
    multihSym2xEn = 1'b0;
    dataSymEn     = 1'b0;
    dataSym2xEn   = 1'b0;
    reportTest("decoder source select", errorsBefore);
  endtask

  task automatic overrideAuqpskPins();
    int          errorsBefore;
    logic [31:0] rnd;
    errorsBefore = errorCount;
    demodMode    = MODE_AUQPSK;
    skipCycles(2);
    for (int i = 0; i < 8; i++) begin
      rnd         = $urandom();
      qData       = rnd[0];
      auSymClk    = rnd[1];
      dataSym2xEn = ~rnd[1];
      bsyncLock   = rnd[2];
      demodLock   = rnd[3];
      sdiIn       = rnd[4];
      skipCycles(1);
      checkBit("cout_q_o AUQPSK", coutQ, auSymClk);
      checkBit("dout_q_o AUQPSK", doutQ, qData);
      checkBit("bsyncNLock_o", bsyncNLock, bsyncLock);
      checkBit("demodNLock_o", demodNLock, demodLock);
      checkBit("sdiOut_o", sdiOut, sdiIn);
    end
    demodMode = 4'h0;
    reportTest("AUQPSK override and pass-throughs", errorsBefore);
  endtask

  //**********************************************************************
  // Main sequence
  //**********************************************************************
  initial begin
    void'($urandom(SEED));
    errorCount    = 0;
    testCount     = 0;
    rs            = 1'b1;
    nCs           = 1'b1;
    nWe           = 1'b1;
    nRd           = 1'b1;
    addr          = '0;
    wrData        = '0;
    demodMode     = 4'h0;
    dacSelect     = '0;
    hostData      = '0;
    trellisData   = '0;
    trellisSync   = '0;
    multihSymEn   = 1'b0;
    multihSym2xEn = 1'b0;
    multihBit     = '0;
    dataSymEn     = 1'b0;
    dataSym2xEn   = 1'b0;
    iData         = 1'b0;
    qData         = 1'b0;
    auSymClk      = 1'b0;
    bsyncLock     = 1'b0;
    demodLock     = 1'b0;
    sdiIn         = 1'b0;
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      dacExp[ch] = offsetBin(hostData[ch]);
    end
    repeat (4) @(posedge ck933);
    @(negedge ck933);
    rs = 1'b0;
    stretchDacReset();
    readVersionWord();
    driveHostSamples();
    driveTrellisSamples();
    selectDecoderSource();
    overrideAuqpskPins();
    $display("Tests run %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
